// File: compile.f
hdl/rf_pkg.sv
hdl/rf_ram.sv
hdl/rf_bypass.sv
hdl/alu_exec.sv
hdl/pipe_stages.sv
hdl/int_pipe_top.sv
tb/int_pipe_chk.sv
tb/int_pipe_tb.sv

// File: hdl/alu_exec.sv
// execute stage alu, register and immediate operations
`default_nettype none

module alu_exec (
   input  wire rf_pkg::alu_op_e     op_i,
   input  wire [rf_pkg::XLEN-1:0]   a_i,
   input  wire [rf_pkg::XLEN-1:0]   b_i,
   input  wire [rf_pkg::IMM_W-1:0]  imm_i,
   output logic [rf_pkg::XLEN-1:0]  result_o
);

   import rf_pkg::*;

   logic [XLEN-1:0] imm_sext;

   // sign extend the 16 bit immediate
   assign imm_sext = {{(XLEN-IMM_W){imm_i[IMM_W-1]}}, imm_i};

   always_comb begin
      case (op_i)
         OP_ADD: begin
            result_o = a_i + b_i;
         end
         OP_SUB: begin
            result_o = a_i - b_i;
         end
         OP_AND: begin
            result_o = a_i & b_i;
         end
         OP_OR: begin
            result_o = a_i | b_i;
         end
         OP_XOR: begin
            result_o = a_i ^ b_i;
         end
         OP_ADDI: begin
            result_o = a_i + imm_sext;
         end
         OP_LI: begin
            result_o = imm_sext;
         end
         // unused encoding
         default: begin
            result_o = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/int_pipe_top.sv
// pipeline top level, stage chain, register file and alu
`default_nettype none

module int_pipe_top (
   input  wire                 clk,
   input  wire                 rst,
   input  wire rf_pkg::insn_t  insn_i,
   input  wire                 insn_valid_i,
   input  wire                 flush_i,
   output rf_pkg::wb_t         wb_o
);

   import rf_pkg::*;

   alu_op_e          exe_op;
   logic [IMM_W-1:0] exe_imm;
   stage_t           exe_stage;
   stage_t           ctrl_stage;
   stage_t           wb_stage;
   logic [XLEN-1:0]  exe_result;
   logic [XLEN-1:0]  rfa;
   logic [XLEN-1:0]  rfb;

   pipe_stages u_stages (
      .clk          (clk),
      .rst          (rst),
      .insn_i       (insn_i),
      .insn_valid_i (insn_valid_i),
      .flush_i      (flush_i),
      .exe_result_i (exe_result),
      .exe_op_o     (exe_op),
      .exe_imm_o    (exe_imm),
      .exe_stage_o  (exe_stage),
      .ctrl_stage_o (ctrl_stage),
      .wb_stage_o   (wb_stage),
      .wb_o         (wb_o)
   );

   // operands read straight from the decode instruction
   rf_bypass u_rf (
      .clk          (clk),
      .rst          (rst),
      .dec_valid_i  (insn_valid_i),
      .rfa_addr_i   (insn_i.ra),
      .rfb_addr_i   (insn_i.rb),
      .exe_stage_i  (exe_stage),
      .ctrl_stage_i (ctrl_stage),
      .wb_stage_i   (wb_stage),
      .rfa_o        (rfa),
      .rfb_o        (rfb)
   );

   alu_exec u_alu (
      .op_i     (exe_op),
      .a_i      (rfa),
      .b_i      (rfb),
      .imm_i    (exe_imm),
      .result_o (exe_result)
   );

endmodule

`default_nettype wire

// File: hdl/pipe_stages.sv
// decode, execute, control and writeback stage registers with flush
`default_nettype none

module pipe_stages (
   input  wire                          clk,
   input  wire                          rst,
   input  wire rf_pkg::insn_t           insn_i,
   input  wire                          insn_valid_i,
   input  wire                          flush_i,
   input  wire [rf_pkg::XLEN-1:0]       exe_result_i,
   output rf_pkg::alu_op_e              exe_op_o,
   output logic [rf_pkg::IMM_W-1:0]     exe_imm_o,
   output rf_pkg::stage_t               exe_stage_o,
   output rf_pkg::stage_t               ctrl_stage_o,
   output rf_pkg::stage_t               wb_stage_o,
   output rf_pkg::wb_t                  wb_o
);

   import rf_pkg::*;

   logic                 exe_valid_q;
   logic [RF_ADDR_W-1:0] exe_rd_q;
   stage_t               ctrl_q;
   stage_t               wb_q;

   // decode to execute, a flush kills the instruction being strobed
   always_ff @(posedge clk) begin
      if (rst) begin
         exe_valid_q <= 1'b0;
      end else begin
         exe_valid_q <= insn_valid_i && !flush_i;
      end
   end

   always_ff @(posedge clk) begin
      exe_rd_q  <= insn_i.rd;
      exe_op_o  <= insn_i.op;
      exe_imm_o <= insn_i.imm;
   end

   always_comb begin
      exe_stage_o.valid  = exe_valid_q;
      exe_stage_o.wr     = exe_valid_q && (exe_rd_q != '0);
      exe_stage_o.rd     = exe_rd_q;
      exe_stage_o.result = exe_result_i;
   end

   // execute to control to writeback
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_q.valid <= 1'b0;
         ctrl_q.wr    <= 1'b0;
         wb_q.valid   <= 1'b0;
         wb_q.wr      <= 1'b0;
      end else begin
         ctrl_q <= exe_stage_o;
         wb_q   <= ctrl_q;
         // instruction in execute is cancelled too
         if (flush_i) begin
            ctrl_q.valid <= 1'b0;
            ctrl_q.wr    <= 1'b0;
         end
      end
   end

   assign ctrl_stage_o = ctrl_q;
   assign wb_stage_o   = wb_q;

   // only results that reach a real register are reported
   always_comb begin
      wb_o.valid = wb_q.wr;
      wb_o.rd    = wb_q.rd;
      wb_o.data  = wb_q.result;
   end

endmodule

`default_nettype wire

// File: hdl/rf_bypass.sv
// register file with two ram copies, hazard detection and result forwarding
`default_nettype none

module rf_bypass (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          dec_valid_i,
   input  wire [rf_pkg::RF_ADDR_W-1:0]  rfa_addr_i,
   input  wire [rf_pkg::RF_ADDR_W-1:0]  rfb_addr_i,
   input  wire rf_pkg::stage_t          exe_stage_i,
   input  wire rf_pkg::stage_t          ctrl_stage_i,
   input  wire rf_pkg::stage_t          wb_stage_i,
   output logic [rf_pkg::XLEN-1:0]      rfa_o,
   output logic [rf_pkg::XLEN-1:0]      rfb_o
);

   import rf_pkg::*;

   // per-operand flags captured at decode
   // exe/ctrl/wb name the stage the producer sat in during decode
   typedef struct packed {
      logic zero;
      logic exe;
      logic ctrl;
      logic wb;
   } hazard_t;

   hazard_t         haz_a_q;
   hazard_t         haz_b_q;
   logic [XLEN-1:0] wb_result_q;
   logic [XLEN-1:0] rfa_ram;
   logic [XLEN-1:0] rfb_ram;

   // compare one operand against the three producer stages
   function automatic hazard_t detect(
      input logic [RF_ADDR_W-1:0] addr,
      input stage_t               exe,
      input stage_t               ctrl,
      input stage_t               wb
   );
      hazard_t h;
      logic    nz;
      nz     = (addr != '0);
      h.zero = !nz;
      h.exe  = nz && exe.wr && (exe.rd == addr);
      h.ctrl = nz && ctrl.wr && (ctrl.rd == addr);
      h.wb   = nz && wb.wr && (wb.rd == addr);
      return h;
   endfunction

   // nearest producer wins, r0 always reads zero
   function automatic logic [XLEN-1:0] select(
      input hazard_t         h,
      input logic [XLEN-1:0] ram,
      input logic [XLEN-1:0] ctrl_res,
      input logic [XLEN-1:0] wb_res,
      input logic [XLEN-1:0] wb_latched
   );
      if (h.zero) begin
         return '0;
      end else if (h.exe) begin
         return ctrl_res;
      end else if (h.ctrl) begin
         return wb_res;
      end else if (h.wb) begin
         return wb_latched;
      end
      return ram;
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         haz_a_q <= '0;
         haz_b_q <= '0;
      end else if (dec_valid_i) begin
         haz_a_q <= detect(rfa_addr_i, exe_stage_i, ctrl_stage_i, wb_stage_i);
         haz_b_q <= detect(rfb_addr_i, exe_stage_i, ctrl_stage_i, wb_stage_i);
      end else begin
         haz_a_q <= '0;
         haz_b_q <= '0;
      end
   end

   // writeback value written during the read cycle, the ram returns the stale word
   always_ff @(posedge clk) begin
      wb_result_q <= wb_stage_i.result;
   end

   always_comb begin
      rfa_o = select(haz_a_q, rfa_ram, ctrl_stage_i.result, wb_stage_i.result,
                     wb_result_q);
      rfb_o = select(haz_b_q, rfb_ram, ctrl_stage_i.result, wb_stage_i.result,
                     wb_result_q);
   end

   // identical copies, one per read port
   rf_ram rfa (
      .clk       (clk),
      .rst       (rst),
      .rd_addr_i (rfa_addr_i),
      .rd_en_i   (dec_valid_i),
      .rd_data_o (rfa_ram),
      .wr_addr_i (wb_stage_i.rd),
      .wr_en_i   (wb_stage_i.wr),
      .wr_data_i (wb_stage_i.result)
   );

   rf_ram rfb (
      .clk       (clk),
      .rst       (rst),
      .rd_addr_i (rfb_addr_i),
      .rd_en_i   (dec_valid_i),
      .rd_data_o (rfb_ram),
      .wr_addr_i (wb_stage_i.rd),
      .wr_en_i   (wb_stage_i.wr),
      .wr_data_i (wb_stage_i.result)
   );

endmodule

`default_nettype wire

// File: hdl/rf_pkg.sv
// widths, alu opcode enum, instruction, stage and writeback structs
`default_nettype none

package rf_pkg;

   // datapath and register file geometry
   localparam int XLEN      = 32;
   localparam int RF_ADDR_W = 5;
   localparam int RF_WORDS  = 32;
   localparam int IMM_W     = 16;

   // alu opcodes, 3 bits
   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_ADDI = 3'd5,
      OP_LI   = 3'd6
   } alu_op_e;

   // instruction as presented at decode
   typedef struct packed {
      alu_op_e                op;
      logic [RF_ADDR_W-1:0]   rd;
      logic [RF_ADDR_W-1:0]   ra;
      logic [RF_ADDR_W-1:0]   rb;
      logic [IMM_W-1:0]       imm;
   } insn_t;

   // one in-flight result
   // wr means valid with a nonzero destination
   typedef struct packed {
      logic                   valid;
      logic                   wr;
      logic [RF_ADDR_W-1:0]   rd;
      logic [XLEN-1:0]        result;
   } stage_t;

   // retire report
   typedef struct packed {
      logic                   valid;
      logic [RF_ADDR_W-1:0]   rd;
      logic [XLEN-1:0]        data;
   } wb_t;

endpackage

`default_nettype wire

// File: hdl/rf_ram.sv
// register file ram with one registered read port and one write port
`default_nettype none

module rf_ram (
   input  wire                          clk,
   input  wire                          rst,
   input  wire [rf_pkg::RF_ADDR_W-1:0]  rd_addr_i,
   input  wire                          rd_en_i,
   output logic [rf_pkg::XLEN-1:0]      rd_data_o,
   input  wire [rf_pkg::RF_ADDR_W-1:0]  wr_addr_i,
   input  wire                          wr_en_i,
   input  wire [rf_pkg::XLEN-1:0]       wr_data_i
);

   import rf_pkg::*;

   logic [XLEN-1:0] mem [RF_WORDS];

   // read returns the old word on a read/write collision
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_data_o <= '0;
      end else if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# builds the pipeline testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module int_pipe_tb \
      -Mdir obj_dir -o sim -f compile.f; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb/int_pipe_chk.sv
// concurrent assertions on the pipeline top level ports
`default_nettype none

module int_pipe_chk (
   input wire                clk,
   input wire                rst,
   input wire                insn_valid_i,
   input wire                flush_i,
   input wire rf_pkg::wb_t   wb_o
);

   // retiring results always name a real register
   a_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
      wb_o.valid |-> wb_o.rd != '0)
      else $error("retire reported for register zero");

   // strobed three cycles back, not cancelled in decode or execute
   a_from_issue: assert property (@(posedge clk) disable iff (rst)
      wb_o.valid |-> $past(insn_valid_i, 3) && !$past(flush_i, 2) && !$past(flush_i, 3))
      else $error("retire without a matching uncancelled strobe");

   a_quiet_in_reset: assert property (@(posedge clk)
      rst && $past(rst) |-> !wb_o.valid)
      else $error("wb_o.valid high during reset");

endmodule

bind int_pipe_top int_pipe_chk chk0 (
   .clk          (clk),
   .rst          (rst),
   .insn_valid_i (insn_valid_i),
   .flush_i      (flush_i),
   .wb_o         (wb_o)
);

`default_nettype wire

// File: tb/int_pipe_tb.sv
// testbench for the integer pipeline, directed tests, reference model and retire monitor
`default_nettype none

module int_pipe_tb;

   import rf_pkg::*;

   // roughly 450 cycles of stimulus, limit leaves a wide margin
   localparam int unsigned TIMEOUT = 2000;

   typedef struct packed {
      logic [RF_ADDR_W-1:0] rd;
      logic [XLEN-1:0]      data;
      logic [31:0]          when;
   } exp_t;

   logic            clk;
   logic            rst;
   insn_t           insn;
   logic            insn_valid;
   logic            flush;
   wb_t             wb;
   logic [31:0]     cyc = '0;
   logic [31:0]     rng;
   logic [XLEN-1:0] model_rf [RF_WORDS];
   exp_t            exp_q [$];
   logic            pend_valid;
   insn_t           pend_insn;
   logic [31:0]     pend_cyc;
   int              errors;
   int              checks;
   int              tests;
   int              err_mark;

   int_pipe_top dut0 (
      .clk          (clk),
      .rst          (rst),
      .insn_i       (insn),
      .insn_valid_i (insn_valid),
      .flush_i      (flush),
      .wb_o         (wb)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc == TIMEOUT) begin
         $display("run stopped after %0d cycles without finishing", TIMEOUT);
         $display("Something failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check(input string name, input logic [31:0] got,
                        input logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("FAIL %s got %h expected %h", name, got, expected);
      end
   endtask

   task automatic report_test(input string name);
      tests++;
      $display("test %s finished with %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   function automatic insn_t make_insn(input alu_op_e op, input int rd, input int ra,
                                       input int rb, input logic [IMM_W-1:0] imm);
      insn_t i;
      i.op  = op;
      i.rd  = RF_ADDR_W'(rd);
      i.ra  = RF_ADDR_W'(ra);
      i.rb  = RF_ADDR_W'(rb);
      i.imm = imm;
      return i;
   endfunction

   // architectural effect of one surviving instruction
   task automatic commit(input insn_t i, input logic [31:0] when);
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      logic [XLEN-1:0] imm;
      logic [XLEN-1:0] res;
      exp_t            e;
      a   = model_rf[i.ra];
      b   = model_rf[i.rb];
      imm = XLEN'($signed(i.imm));
      case (i.op)
         OP_ADD:  res = a + b;
         OP_SUB:  res = a - b;
         OP_AND:  res = a & b;
         OP_OR:   res = a | b;
         OP_XOR:  res = a ^ b;
         OP_ADDI: res = a + imm;
         OP_LI:   res = imm;
         default: res = '0;
      endcase
      if (i.rd != '0) begin
         model_rf[i.rd] = res;
         e.rd   = i.rd;
         e.data = res;
         e.when = when + 3;
         exp_q.push_back(e);
      end
   endtask

   // an instruction survives when no flush lands in its decode or execute cycle
   task automatic drive(input logic vld, input insn_t i, input logic fl);
      @(negedge clk);
      if (pend_valid && !fl) begin
         commit(pend_insn, pend_cyc);
      end
      pend_valid = vld && !fl;
      pend_insn  = i;
      pend_cyc   = cyc;
      insn_valid = vld;
      insn       = i;
      flush      = fl;
   endtask

   task automatic issue(input insn_t i);
      drive(1'b1, i, 1'b0);
   endtask

   task automatic idle(input int n);
      repeat (n) drive(1'b0, '0, 1'b0);
   endtask

   always @(negedge clk) begin : monitor
      exp_t e;
      if (!rst && wb.valid) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("unexpected retire of r%0d with data %h", wb.rd, wb.data);
         end else begin
            e = exp_q.pop_front();
            check("wb_o.rd", 32'(wb.rd), 32'(e.rd));
            check("wb_o.data", wb.data, e.data);
            check("retire cycle", cyc, e.when);
         end
      end
   end

   task automatic test_reset();
      repeat (16) begin
         @(negedge clk);
         check("wb_o.valid", 32'(wb.valid), 32'd0);
      end
      rst = 1'b0;
      repeat (6) begin
         idle(1);
         check("wb_o.valid", 32'(wb.valid), 32'd0);
      end
      report_test("reset");
   endtask

   task automatic test_independent();
      for (int r = 1; r < RF_WORDS; r++) begin
         issue(make_insn(OP_LI, r, 0, 0, IMM_W'(r * 2477)));
      end
      idle(4);
      for (int k = 0; k < 7; k++) begin
         issue(make_insn(alu_op_e'(3'(k)), k + 1, k + 9, 31 - k, IMM_W'(32'h8001 + k * 4660)));
         idle(4);
      end
      report_test("independent");
   endtask

   task automatic test_forwarding();
      for (int d = 1; d <= 4; d++) begin
         for (int side = 0; side < 2; side++) begin
            issue(make_insn(OP_LI, 10, 0, 0, IMM_W'(d * 300 + side)));
            idle(d - 1);
            // sub so that the operand order matters
            if (side == 0) begin
               issue(make_insn(OP_SUB, 11, 10, 3, '0));
            end else begin
               issue(make_insn(OP_SUB, 11, 3, 10, '0));
            end
            idle(4);
         end
      end
      issue(make_insn(OP_LI, 12, 0, 0, 16'h1111));
      issue(make_insn(OP_LI, 12, 0, 0, 16'h2222));
      issue(make_insn(OP_ADD, 13, 12, 12, '0));
      // chain keeps r12 live in control, writeback and the latch at once
      repeat (3) issue(make_insn(OP_ADDI, 12, 12, 0, 16'hfff1));
      issue(make_insn(OP_XOR, 14, 12, 13, '0));
      idle(5);
      report_test("forwarding");
   endtask

   task automatic test_zero();
      issue(make_insn(OP_LI, 0, 0, 0, 16'h7fff));
      issue(make_insn(OP_ADD, 5, 0, 0, '0));
      issue(make_insn(OP_ADDI, 6, 0, 0, 16'h0055));
      issue(make_insn(OP_OR, 7, 0, 1, '0));
      issue(make_insn(OP_ADD, 0, 1, 2, '0));
      issue(make_insn(OP_SUB, 8, 0, 0, '0));
      issue(make_insn(OP_ADD, 9, 0, 2, '0));
      issue(make_insn(OP_XOR, 15, 3, 0, '0));
      idle(5);
      report_test("register zero");
   endtask

   task automatic test_flush();
      issue(make_insn(OP_LI, 22, 0, 0, 16'h0aaa));
      issue(make_insn(OP_LI, 23, 0, 0, 16'h0bbb));
      idle(4);
      issue(make_insn(OP_ADDI, 20, 1, 0, 16'h0010));
      issue(make_insn(OP_ADDI, 21, 2, 0, 16'h0020));
      issue(make_insn(OP_LI, 22, 0, 0, 16'h7777));
      drive(1'b1, make_insn(OP_LI, 23, 0, 0, 16'h6666), 1'b1);
      issue(make_insn(OP_ADD, 25, 22, 21, '0));
      idle(4);
      issue(make_insn(OP_SUB, 24, 22, 23, '0));
      idle(5);
      report_test("flush");
   endtask

   task automatic test_random();
      logic [31:0] r1;
      logic [31:0] r2;
      for (int n = 0; n < 200; n++) begin
         rng = xorshift(rng);
         r1  = rng;
         rng = xorshift(rng);
         r2  = rng;
         drive(1'b1, make_insn(alu_op_e'(3'(r1 % 7)), int'(r1[9:5]), int'(r1[14:10]),
                               int'(r1[19:15]), r2[31:16]), r2[3:0] == 4'h0);
      end
      idle(6);
      check("expectation queue size", 32'(exp_q.size()), 32'd0);
      report_test("random");
   endtask

   initial begin
      rst        = 1'b1;
      insn       = '0;
      insn_valid = 1'b0;
      flush      = 1'b0;
      rng        = 32'd5;
      pend_valid = 1'b0;
      pend_insn  = '0;
      pend_cyc   = '0;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      err_mark   = 0;
      for (int r = 0; r < RF_WORDS; r++) begin
         model_rf[r] = '0;
      end
      test_reset();
      test_independent();
      test_forwarding();
      test_zero();
      test_flush();
      test_random();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
